//--- source/opq_pkg.sv
/* Operand path package
   Datapath, length, address and command types shared by fetch and queue */
package opq_pkg;

  // One datapath word
  typedef logic [63:0] elen_t;

  // Element count of a command
  typedef logic [7:0] vlen_t;

  // Word address into the register bank
  typedef logic [3:0] vaddr_t;

  // Bank size, matches the vaddr_t range
  localparam int unsigned NrVrfWords = 16;

  // Source element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  // Conversion applied on the way out of the queue
  typedef enum logic [1:0] {
    ConvNone = 2'd0,
    ConvSExt = 2'd1,
    ConvZExt = 2'd2
  } conv_e;

  // Command shared by fetch and queue
  typedef struct packed {
    vaddr_t vs;
    vlen_t  vl;
    ew_e    eew;
    conv_e  conv;
  } opq_cmd_t;

endpackage

//--- source/opq_operand_if.sv
/* Operand link between the fetch unit and the operand queue
   Issue pulse, registered operand one cycle later, credit-based ready */
`timescale 1ns/1ns

interface opq_operand_if;

  // Bank word on its way to the queue
  opq_pkg::elen_t operand;
  logic           operand_valid;
  // Read issued this cycle, data follows next cycle
  logic           operand_issued;
  // Queue still has credit for one more read
  logic           queue_ready;

  modport fetch (
    output operand,
    output operand_valid,
    output operand_issued,
    input  queue_ready
  );

  modport queue (
    input  operand,
    input  operand_valid,
    input  operand_issued,
    output queue_ready
  );

endinterface

//--- source/opq_fifo.sv
/* Synchronous FIFO, circular buffer with full and empty flags
   Output shows the head entry, a pushed word appears one cycle later */
`timescale 1ns/1ns

module opq_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  dtype            mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  // Head entry straight from storage
  assign data_o = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth, not at a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      unique case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Overflow and underflow
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("push into full FIFO");
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("pop from empty FIFO");

endmodule

//--- source/vrf_fetch.sv
/* Vector register bank with a read sequencer
   Issues one word read per cycle for each command while the queue has credit */
`timescale 1ns/1ns

module vrf_fetch (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Bank write port
  input  logic                wr_en_i,
  input  opq_pkg::vaddr_t     wr_addr_i,
  input  opq_pkg::elen_t      wr_data_i,
  // Command
  input  opq_pkg::opq_cmd_t   cmd_i,
  input  logic                cmd_push_i,
  output logic                idle_o,
  // Operand link
  opq_operand_if.fetch        opif
);

  typedef enum logic {
    FetchIdle,
    FetchRun
  } fetch_state_e;

  fetch_state_e    state_d, state_q;
  opq_pkg::elen_t  bank_q [opq_pkg::NrVrfWords];
  opq_pkg::vaddr_t addr_q;
  opq_pkg::vlen_t  left_q;
  opq_pkg::vlen_t  words;
  logic [1:0]      epw_log;
  logic [8:0]      words_sum;
  logic            issue;
  opq_pkg::elen_t  rdata_q;
  logic            rvalid_q;

  // Words needed: vl over elements per word, rounded up
  // log2 of elements per word is 3 - eew
  assign epw_log   = 2'(3 - int'(cmd_i.eew));
  assign words_sum = {1'b0, cmd_i.vl} + 9'((1 << epw_log) - 1);
  assign words     = opq_pkg::vlen_t'(words_sum >> epw_log);

  // Bank write, seen by a read in the next cycle
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      bank_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Sequencer
  always_comb begin
    state_d = state_q;
    issue   = 1'b0;
    unique case (state_q)
      FetchIdle: begin
        if (cmd_push_i) begin
          state_d = FetchRun;
        end
      end
      FetchRun: begin
        // Empty run, nothing to read
        if (left_q == '0) begin
          state_d = FetchIdle;
        end else if (opif.queue_ready) begin
          issue = 1'b1;
          if (left_q == opq_pkg::vlen_t'(1)) begin
            state_d = FetchIdle;
          end
        end
      end
      default: state_d = FetchIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FetchIdle;
      addr_q  <= '0;
      left_q  <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_push_i && state_q == FetchIdle) begin
        addr_q <= cmd_i.vs;
        left_q <= words;
      end else if (issue) begin
        // Address wraps around the bank
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
      end
    end
  end

  // Read data register, valid one cycle after the issue
  always_ff @(posedge clk_i) begin
    if (issue) begin
      rdata_q <= bank_q[addr_q];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= issue;
    end
  end

  assign opif.operand        = rdata_q;
  assign opif.operand_valid  = rvalid_q;
  assign opif.operand_issued = issue;
  assign idle_o              = (state_q == FetchIdle);

  // Top level must hold commands back while a run is in progress
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_push_i |-> state_q == FetchIdle)
    else $error("command pushed while fetch busy");

endmodule

//--- source/operand_queue.sv
/* Operand queue with credit-based input buffer
   Delivers buffered words to the consumers, optionally widening each half */
`timescale 1ns/1ns

module operand_queue #(
  parameter int unsigned BufferDepth = 2,
  parameter int unsigned NrConsumers = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Command from the top level
  input  opq_pkg::opq_cmd_t      cmd_i,
  input  logic                   cmd_push_i,
  output logic                   cmd_full_o,
  // Operand link from fetch
  opq_operand_if.queue           opif,
  // Consumers
  output opq_pkg::elen_t         operand_o,
  output logic                   operand_valid_o,
  input  logic [NrConsumers-1:0] operand_ready_i
);

  localparam int unsigned CreditW = $clog2(BufferDepth + 1);

  opq_pkg::opq_cmd_t    cmd;
  logic                 cmd_empty;
  logic                 cmd_pop;
  opq_pkg::elen_t       ibuf_operand;
  logic                 ibuf_empty;
  logic                 ibuf_pop;
  logic [CreditW-1:0]   credit_d, credit_q;
  opq_pkg::elen_t       conv_operand;
  logic [31:0]          half;
  logic                 sext;
  logic                 select_d, select_q;
  logic [8:0]           cnt_d, cnt_q;
  logic                 widen;

  // Commands waiting for their operands
  opq_fifo #(
    .Depth (BufferDepth),
    .dtype (opq_pkg::opq_cmd_t)
  ) u_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_push_i),
    .data_i  (cmd_i),
    .pop_i   (cmd_pop),
    .data_o  (cmd),
    .full_o  (cmd_full_o),
    .empty_o (cmd_empty)
  );

  // Operand buffer, overflow prevented by the credit count
  opq_fifo #(
    .Depth (BufferDepth),
    .dtype (opq_pkg::elen_t)
  ) u_operand_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (opif.operand_valid),
    .data_i  (opif.operand),
    .pop_i   (ibuf_pop),
    .data_o  (ibuf_operand),
    .full_o  (),
    .empty_o (ibuf_empty)
  );

  // Credit: reads in flight plus words held
  always_comb begin
    credit_d = credit_q;
    if (opif.operand_issued) begin
      credit_d = credit_d + 1'b1;
    end
    if (ibuf_pop) begin
      credit_d = credit_d - 1'b1;
    end
  end

  assign opif.queue_ready = (credit_q < CreditW'(BufferDepth));

  // Widening of the selected half
  assign widen = (cmd.conv == opq_pkg::ConvSExt) || (cmd.conv == opq_pkg::ConvZExt);
  assign sext  = (cmd.conv == opq_pkg::ConvSExt);
  assign half  = select_q ? ibuf_operand[63:32] : ibuf_operand[31:0];

  always_comb begin
    conv_operand = ibuf_operand;
    if (widen) begin
      unique case (cmd.eew)
        opq_pkg::EW8: begin
          for (int e = 0; e < 4; e++) begin
            conv_operand[16*e +: 16] = {{8{sext & half[8*e+7]}}, half[8*e +: 8]};
          end
        end
        opq_pkg::EW16: begin
          for (int e = 0; e < 2; e++) begin
            conv_operand[32*e +: 32] = {{16{sext & half[16*e+15]}}, half[16*e +: 16]};
          end
        end
        opq_pkg::EW32: conv_operand = {{32{sext & half[31]}}, half};
        // EW64 cannot widen, word passes unchanged
        default: conv_operand = ibuf_operand;
      endcase
    end
  end

  assign operand_o       = conv_operand;
  assign operand_valid_o = !ibuf_empty;

  // Output sequencing and element count
  always_comb begin
    ibuf_pop = 1'b0;
    cmd_pop  = 1'b0;
    select_d = select_q;
    cnt_d    = cnt_q;
    if (operand_valid_o && |operand_ready_i) begin
      // Elements per output word, halved when widening
      if (widen) begin
        cnt_d    = cnt_q + 9'(4 >> int'(cmd.eew));
        select_d = !select_q;
      end else begin
        cnt_d = cnt_q + 9'(8 >> int'(cmd.eew));
      end
      // Word used up after its high half
      if (select_q || !widen) begin
        ibuf_pop = 1'b1;
      end
      // Last word of the command, even if only the low half was needed
      if (cnt_d >= {1'b0, cmd.vl}) begin
        ibuf_pop = 1'b1;
        cmd_pop  = 1'b1;
        select_d = 1'b0;
        cnt_d    = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
      select_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      credit_q <= credit_d;
      select_q <= select_d;
      cnt_q    <= cnt_d;
    end
  end

  // Widening needs a narrower source than the datapath
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_push_i && cmd_i.conv != opq_pkg::ConvNone |-> cmd_i.eew != opq_pkg::EW64)
    else $error("widening requested with EW64");

  // Fetch only sends words for accepted commands
  assert property (@(posedge clk_i) disable iff (!rst_ni) operand_valid_o |-> !cmd_empty)
    else $error("operand without command");

endmodule

//--- source/opq_top.sv
/* Operand path top level
   Register bank fetch feeding the operand queue, command accept logic */
`timescale 1ns/1ns

module opq_top #(
  parameter int unsigned BufferDepth = 2,
  parameter int unsigned NrConsumers = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Bank write port
  input  logic                   wr_en_i,
  input  opq_pkg::vaddr_t        wr_addr_i,
  input  opq_pkg::elen_t         wr_data_i,
  // Command
  input  opq_pkg::opq_cmd_t      cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  // Consumers
  output opq_pkg::elen_t         operand_o,
  output logic                   operand_valid_o,
  input  logic [NrConsumers-1:0] operand_ready_i
);

  logic fetch_idle;
  logic cmd_full;
  logic cmd_accept;

  opq_operand_if u_opif ();

  // One command at a time in fetch, queue must have room for it
  assign cmd_ready_o = fetch_idle && !cmd_full;
  assign cmd_accept  = cmd_valid_i && cmd_ready_o;

  vrf_fetch u_fetch (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (wr_en_i),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i),
    .cmd_i      (cmd_i),
    .cmd_push_i (cmd_accept),
    .idle_o     (fetch_idle),
    .opif       (u_opif.fetch)
  );

  operand_queue #(
    .BufferDepth (BufferDepth),
    .NrConsumers (NrConsumers)
  ) u_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd_i),
    .cmd_push_i      (cmd_accept),
    .cmd_full_o      (cmd_full),
    .opif            (u_opif.queue),
    .operand_o       (operand_o),
    .operand_valid_o (operand_valid_o),
    .operand_ready_i (operand_ready_i)
  );

endmodule

//--- tests/tb_clock_gen.sv
/* Testbench clock and reset source */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int Period      = 40,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, away from the sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- tests/opq_tb.sv
/* Operand path testbench
   Table of commands checked against a model of the bank and the widening rules */
`timescale 1ns/1ns

module opq_tb;

  localparam int BufferDepth   = 2;
  localparam int NrConsumers   = 2;
  localparam int NrRows        = 14;
  // Per command budget plus reset and bank load
  localparam int TimeoutCycles = NrRows * 200 + 40;

  // One command, its ready-drop percentage and its output word count
  typedef struct packed {
    opq_pkg::vaddr_t vs;
    opq_pkg::vlen_t  vl;
    opq_pkg::ew_e    eew;
    opq_pkg::conv_e  conv;
    logic [6:0]      drop;
    opq_pkg::vlen_t  nr_out;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   wr_en;
  opq_pkg::vaddr_t        wr_addr;
  opq_pkg::elen_t         wr_data;
  opq_pkg::opq_cmd_t      cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;
  opq_pkg::elen_t         operand;
  logic                   operand_valid;
  logic [NrConsumers-1:0] operand_ready;

  row_t           rows [NrRows];
  opq_pkg::elen_t bank [opq_pkg::NrVrfWords];
  // Expected stream, one entry per output word
  opq_pkg::elen_t exp_word [$];
  int             exp_row [$];
  bit             exp_last [$];
  integer         seed;
  bit             bank_loaded = 1'b0;
  int             n_checks = 0;
  int             n_errors = 0;
  int             accepts = 0;
  int             cmds_done = 0;
  int             total_out = 0;
  int             total_exp = 0;

  tb_clock_gen #(
    .Period      (40),
    .ResetCycles (2)
  ) u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  opq_top #(
    .BufferDepth (BufferDepth),
    .NrConsumers (NrConsumers)
  ) u_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .wr_en_i         (wr_en),
    .wr_addr_i       (wr_addr),
    .wr_data_i       (wr_data),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .cmd_ready_o     (cmd_ready),
    .operand_o       (operand),
    .operand_valid_o (operand_valid),
    .operand_ready_i (operand_ready)
  );

  task automatic check_operand(string name, opq_pkg::elen_t got, opq_pkg::elen_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, opq_pkg::vlen_t got, opq_pkg::vlen_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Source element width in bits
  function automatic int elem_bits(opq_pkg::ew_e eew);
    case (eew)
      opq_pkg::EW8:  return 8;
      opq_pkg::EW16: return 16;
      opq_pkg::EW32: return 32;
      default:       return 64;
    endcase
  endfunction

  // Output word for one source word, widening the chosen half element by element
  function automatic opq_pkg::elen_t model_word(opq_pkg::elen_t src, opq_pkg::ew_e eew,
                                                opq_pkg::conv_e conv, bit hi);
    int          w;
    logic [63:0] half;
    logic [63:0] elem;
    logic [63:0] mask;
    logic [63:0] result;
    if (conv == opq_pkg::ConvNone) begin
      return src;
    end
    w      = elem_bits(eew);
    mask   = (64'd1 << w) - 64'd1;
    half   = hi ? (src >> 32) : (src & 64'hffff_ffff);
    result = '0;
    for (int e = 0; e < 32 / w; e++) begin
      elem = (half >> (e * w)) & mask;
      // Sign fill copies the element's top bit into the upper half
      if (conv == opq_pkg::ConvSExt && elem[w-1]) begin
        elem = elem | (mask << w);
      end
      result = result | (elem << (2 * e * w));
    end
    return result;
  endfunction

  // Start word, vl, eew, conv, ready drop in percent, output words
  task automatic load_table();
    rows[0]  = '{4'd0,  8'd16, opq_pkg::EW8,  opq_pkg::ConvNone, 7'd0,  8'd2};
    rows[1]  = '{4'd2,  8'd13, opq_pkg::EW8,  opq_pkg::ConvNone, 7'd0,  8'd2};
    rows[2]  = '{4'd4,  8'd7,  opq_pkg::EW16, opq_pkg::ConvNone, 7'd0,  8'd2};
    rows[3]  = '{4'd6,  8'd5,  opq_pkg::EW32, opq_pkg::ConvNone, 7'd0,  8'd3};
    rows[4]  = '{4'd9,  8'd3,  opq_pkg::EW64, opq_pkg::ConvNone, 7'd0,  8'd3};
    rows[5]  = '{4'd12, 8'd16, opq_pkg::EW8,  opq_pkg::ConvSExt, 7'd0,  8'd4};
    rows[6]  = '{4'd14, 8'd6,  opq_pkg::EW16, opq_pkg::ConvSExt, 7'd0,  8'd3};
    rows[7]  = '{4'd1,  8'd3,  opq_pkg::EW32, opq_pkg::ConvSExt, 7'd0,  8'd3};
    rows[8]  = '{4'd5,  8'd8,  opq_pkg::EW8,  opq_pkg::ConvZExt, 7'd30, 8'd2};
    rows[9]  = '{4'd7,  8'd4,  opq_pkg::EW16, opq_pkg::ConvZExt, 7'd30, 8'd2};
    rows[10] = '{4'd10, 8'd4,  opq_pkg::EW32, opq_pkg::ConvZExt, 7'd50, 8'd4};
    rows[11] = '{4'd3,  8'd12, opq_pkg::EW8,  opq_pkg::ConvSExt, 7'd60, 8'd3};
    rows[12] = '{4'd8,  8'd9,  opq_pkg::EW16, opq_pkg::ConvNone, 7'd50, 8'd3};
    rows[13] = '{4'd0,  8'd32, opq_pkg::EW8,  opq_pkg::ConvZExt, 7'd40, 8'd8};
    for (int r = 0; r < NrRows; r++) begin
      total_exp += int'(rows[r].nr_out);
    end
  endtask

  // Random fill through the write port, kept in a local copy
  task automatic load_bank();
    for (int a = 0; a < opq_pkg::NrVrfWords; a++) begin
      @(posedge clk);
      #1;
      bank[a] = {$random(seed), $random(seed)};
      wr_en   = 1'b1;
      wr_addr = opq_pkg::vaddr_t'(a);
      wr_data = bank[a];
    end
    @(posedge clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic push_expected(int r);
    int per_word;
    int per_out;
    int nr_out;
    int addr;
    bit widen;
    widen    = (rows[r].conv != opq_pkg::ConvNone);
    per_word = 64 / elem_bits(rows[r].eew);
    // Widened output words carry half a source word each
    per_out  = widen ? per_word / 2 : per_word;
    nr_out   = (int'(rows[r].vl) + per_out - 1) / per_out;
    check_count("table word count", opq_pkg::vlen_t'(nr_out), rows[r].nr_out);
    for (int k = 0; k < nr_out; k++) begin
      addr = (int'(rows[r].vs) + (widen ? k / 2 : k)) % opq_pkg::NrVrfWords;
      exp_word.push_back(model_word(bank[addr], rows[r].eew, rows[r].conv, widen && k[0]));
      exp_row.push_back(r);
      exp_last.push_back(k == nr_out - 1);
    end
  endtask

  // Hold the command until it is taken, checking ready against queue fill
  task automatic send_command(int r);
    bit accepted;
    accepted = 1'b0;
    @(posedge clk);
    #1;
    cmd       = '{vs: rows[r].vs, vl: rows[r].vl, eew: rows[r].eew, conv: rows[r].conv};
    cmd_valid = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      if (accepts - cmds_done >= BufferDepth) begin
        check_flag("cmd_ready_o", cmd_ready, 1'b0);
      end
      if (cmd_ready) begin
        accepted = 1'b1;
        accepts++;
        push_expected(r);
      end else begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // All, one or no consumer ready, by the row's drop rate
  task automatic drive_ready(int r);
    int unsigned roll;
    int unsigned pick;
    roll = $unsigned($random(seed));
    pick = $unsigned($random(seed));
    if (roll % 100 < rows[r].drop) begin
      operand_ready = '0;
    end else if (pick[8]) begin
      operand_ready = '1;
    end else begin
      operand_ready = NrConsumers'(1) << (pick % NrConsumers);
    end
  endtask

  initial begin : driver
    seed      = 96;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    cmd       = '0;
    cmd_valid = 1'b0;
    load_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_flag("operand_valid_o", operand_valid, 1'b0);
    check_flag("cmd_ready_o", cmd_ready, 1'b1);
    load_bank();
    bank_loaded = 1'b1;
    for (int r = 0; r < NrRows; r++) begin
      send_command(r);
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    wait (cmds_done == NrRows);
    // No stray word after the last command
    repeat (4) begin
      @(negedge clk);
      check_flag("operand_valid_o", operand_valid, 1'b0);
    end
    check_count("total output words", opq_pkg::vlen_t'(total_out),
                opq_pkg::vlen_t'(total_exp));
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Transfers decided at the falling edge, counters advance at the rising edge
  initial begin : monitor
    bit take;
    bit done;
    int r;
    int row_words;
    operand_ready = '0;
    r             = 0;
    row_words     = 0;
    wait (bank_loaded);
    forever begin
      @(negedge clk);
      take = operand_valid && (|operand_ready);
      done = 1'b0;
      if (take) begin
        total_out++;
        if (exp_word.size() == 0) begin
          n_errors++;
          $display("Unexpected output word %h at %0t ns with no word pending", operand, $time);
        end else begin
          check_operand("operand_o", operand, exp_word.pop_front());
          r    = exp_row.pop_front();
          done = exp_last.pop_front();
          row_words++;
        end
      end
      @(posedge clk);
      if (done) begin
        cmds_done++;
        $display("Row %0d done: %0d words, %0d errors so far", r, row_words, n_errors);
        row_words = 0;
      end
      #1;
      drive_ready(exp_row.size() != 0 ? exp_row[0] : r);
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout after %0d cycles, output stream never completed", TimeoutCycles);
    $display("test failed");
    $finish;
  end

endmodule

//--- build.f
source/opq_pkg.sv
source/opq_operand_if.sv
source/opq_fifo.sv
source/vrf_fetch.sv
source/operand_queue.sv
source/opq_top.sv
tests/tb_clock_gen.sv
tests/opq_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the operand path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module opq_tb -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vopq_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the simulation output alone
if printf '%s\n' "$sim_out" | grep -qx 'test passed'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
